//--- rtl/pixel_pipeline_params.svh
`ifndef PIXEL_PIPELINE_PARAMS_SVH
`define PIXEL_PIPELINE_PARAMS_SVH

////////////////////////////////////////
// Fragment field widths
////////////////////////////////////////

// Bits per color channel
`define PP_SUB_PIXEL_WIDTH 8
`define PP_DEPTH_WIDTH 16
`define PP_INDEX_WIDTH 14
`define PP_SCREEN_POS_WIDTH 11
// IEEE single precision attributes
`define PP_FLOAT_WIDTH 32

// Stage latencies in clock cycles
`define PP_CONVERT_LATENCY 2
`define PP_BLEND_LATENCY 2

`endif

//--- rtl/pixel_pipeline_pkg.sv
`include "pixel_pipeline_params.svh"

package pixel_pipeline_pkg;

    // Raw attribute from the interpolator
    typedef logic [`PP_FLOAT_WIDTH - 1 : 0] float_t;

    typedef logic [`PP_SUB_PIXEL_WIDTH - 1 : 0] channel_t;

    // R in the upper byte, A in the lowest
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
        channel_t a;
    } color_t;

    typedef logic [`PP_DEPTH_WIDTH - 1 : 0] depth_t;

    // Fragment data that rides beside the math
    typedef struct packed {
        logic [`PP_INDEX_WIDTH - 1 : 0]      index;
        logic [`PP_SCREEN_POS_WIDTH - 1 : 0] screen_x;
        logic [`PP_SCREEN_POS_WIDTH - 1 : 0] screen_y;
        logic                                keep;
        logic                                last;
    } sideband_t;

endpackage

//--- rtl/float_to_fixed.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module float_to_fixed
#(
    parameter int FRAC_WIDTH = 8
)
(
    input  logic                           aclk,
    input  logic                           rst_n,
    input  pixel_pipeline_pkg::float_t     value,
    output logic [FRAC_WIDTH - 1 : 0]      fixed
);
    localparam int EXP_WIDTH   = 8;
    localparam int MANT_WIDTH  = `PP_FLOAT_WIDTH - EXP_WIDTH - 1;
    localparam int BIAS        = (1 << (EXP_WIDTH - 1)) - 1;
    localparam int SHIFT_WIDTH = $clog2(MANT_WIDTH + 1);

    logic                       sign;
    logic [EXP_WIDTH - 1 : 0]   exponent;
    logic [MANT_WIDTH : 0]      significand;
    logic [SHIFT_WIDTH - 1 : 0] shift;

    logic                       sign_q;
    logic                       below_q;
    logic                       above_q;
    logic [FRAC_WIDTH - 1 : 0]  aligned_q;

    assign sign        = value[`PP_FLOAT_WIDTH - 1];
    assign exponent    = value[MANT_WIDTH +: EXP_WIDTH];
    assign significand = {1'b1, value[MANT_WIDTH - 1 : 0]};

    // Drops everything below 2^-F, only meaningful for values in [2^-F, 1)
    assign shift = SHIFT_WIDTH'(BIAS + MANT_WIDTH - FRAC_WIDTH - int'(exponent));

    // Stage 1: range compare and mantissa alignment
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sign_q    <= 1'b0;
            below_q   <= 1'b0;
            above_q   <= 1'b0;
            aligned_q <= '0;
        end
        else
        begin
            sign_q    <= sign;
            below_q   <= int'(exponent) < (BIAS - FRAC_WIDTH);
            above_q   <= int'(exponent) >= BIAS;
            aligned_q <= FRAC_WIDTH'(significand >> shift);
        end
    end

    // Stage 2: clamp, negative values win over saturation
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            fixed <= '0;
        else if (sign_q || below_q)
            fixed <= '0;
        else if (above_q)
            fixed <= '1;
        else
            fixed <= aligned_q;
    end

endmodule

//--- rtl/attribute_convert.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module attribute_convert
(
    input  logic                         aclk,
    input  logic                         rst_n,

    input  pixel_pipeline_pkg::float_t   attrb_r,
    input  pixel_pipeline_pkg::float_t   attrb_g,
    input  pixel_pipeline_pkg::float_t   attrb_b,
    input  pixel_pipeline_pkg::float_t   attrb_a,
    input  pixel_pipeline_pkg::float_t   attrb_depth_z,
    input  pixel_pipeline_pkg::float_t   attrb_depth_w,

    output pixel_pipeline_pkg::color_t   conv_color,
    output pixel_pipeline_pkg::depth_t   conv_depth,
    output pixel_pipeline_pkg::channel_t conv_fog
);
    pixel_pipeline_pkg::channel_t red;
    pixel_pipeline_pkg::channel_t green;
    pixel_pipeline_pkg::channel_t blue;
    pixel_pipeline_pkg::channel_t alpha;

    ////////////////////////////////////////
    // Primary color
    ////////////////////////////////////////
    float_to_fixed #(.FRAC_WIDTH(`PP_SUB_PIXEL_WIDTH)) u_conv_r (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_r), .fixed(red)
    );
    float_to_fixed #(.FRAC_WIDTH(`PP_SUB_PIXEL_WIDTH)) u_conv_g (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_g), .fixed(green)
    );
    float_to_fixed #(.FRAC_WIDTH(`PP_SUB_PIXEL_WIDTH)) u_conv_b (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_b), .fixed(blue)
    );
    float_to_fixed #(.FRAC_WIDTH(`PP_SUB_PIXEL_WIDTH)) u_conv_a (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_a), .fixed(alpha)
    );

    assign conv_color = {red, green, blue, alpha};

    ////////////////////////////////////////
    // Depth and fog coordinate
    ////////////////////////////////////////
    float_to_fixed #(.FRAC_WIDTH(`PP_DEPTH_WIDTH)) u_conv_z (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_depth_z), .fixed(conv_depth)
    );

    // Clamped w is used directly as the fog factor
    float_to_fixed #(.FRAC_WIDTH(`PP_SUB_PIXEL_WIDTH)) u_conv_w (
        .aclk(aclk), .rst_n(rst_n), .value(attrb_depth_w), .fixed(conv_fog)
    );

endmodule

//--- rtl/value_delay.sv
`timescale 1ns/1ns

module value_delay
#(
    parameter type payload_t = logic,
    parameter int  DELAY     = 1
)
(
    input  logic     aclk,
    input  logic     rst_n,
    input  payload_t in_data,
    output payload_t out_data
);
    // One item per stage, oldest at the end
    payload_t stages [DELAY];

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DELAY; i++)
            begin
                stages[i] <= '0;
            end
        end
        else
        begin
            stages[0] <= in_data;
            for (int i = 1; i < DELAY; i++)
            begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign out_data = stages[DELAY - 1];

endmodule

//--- rtl/fog_blend.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module fog_blend
(
    input  logic                         aclk,
    input  logic                         rst_n,
    input  logic                         fog_enable,
    input  pixel_pipeline_pkg::color_t   fog_color,
    input  pixel_pipeline_pkg::color_t   color,
    input  pixel_pipeline_pkg::channel_t fog,
    output pixel_pipeline_pkg::color_t   blended
);
    localparam int W          = `PP_SUB_PIXEL_WIDTH;
    localparam int LANES      = 4;
    localparam int PROD_WIDTH = 2 * W;
    localparam logic [PROD_WIDTH : 0] ROUND = (PROD_WIDTH + 1)'(1 << (W - 1));

    logic [LANES - 1 : 0][W - 1 : 0]          color_lanes;
    logic [LANES - 1 : 0][W - 1 : 0]          fog_lanes;
    pixel_pipeline_pkg::channel_t             fog_inv;

    logic [LANES - 1 : 0][PROD_WIDTH - 1 : 0] frag_prod_q;
    logic [LANES - 1 : 0][PROD_WIDTH - 1 : 0] fog_prod_q;
    pixel_pipeline_pkg::color_t               color_q;
    logic                                     enable_q;

    logic [LANES - 1 : 0][PROD_WIDTH : 0]     rounded;
    logic [LANES - 1 : 0][W - 1 : 0]          mixed;

    assign color_lanes = color;
    assign fog_lanes   = fog_color;
    // Weight of the fog color, 255 - f
    assign fog_inv     = {W{1'b1}} - fog;

    // Stage 1: both products per channel
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frag_prod_q <= '0;
            fog_prod_q  <= '0;
            color_q     <= '0;
            enable_q    <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < LANES; i++)
            begin
                frag_prod_q[i] <= color_lanes[i] * fog;
                fog_prod_q[i]  <= fog_lanes[i] * fog_inv;
            end
            color_q  <= color;
            enable_q <= fog_enable;
        end
    end

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            rounded[i] = (PROD_WIDTH + 1)'(frag_prod_q[i]) + fog_prod_q[i] + ROUND;
            mixed[i]   = rounded[i][W +: W];
        end
    end

    // Stage 2: sum, round and pick the path
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            blended <= '0;
        else
            blended <= enable_q ? pixel_pipeline_pkg::color_t'(mixed) : color_q;
    end

endmodule

//--- rtl/pixel_pipeline.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module pixel_pipeline
(
    input  logic                                 aclk,
    input  logic                                 rst_n,

    // Fragment attributes
    input  logic                                 attrb_valid,
    input  pixel_pipeline_pkg::float_t           attrb_r,
    input  pixel_pipeline_pkg::float_t           attrb_g,
    input  pixel_pipeline_pkg::float_t           attrb_b,
    input  pixel_pipeline_pkg::float_t           attrb_a,
    input  pixel_pipeline_pkg::float_t           attrb_depth_z,
    input  pixel_pipeline_pkg::float_t           attrb_depth_w,
    input  logic [`PP_INDEX_WIDTH - 1 : 0]       attrb_index,
    input  logic [`PP_SCREEN_POS_WIDTH - 1 : 0]  attrb_screen_x,
    input  logic [`PP_SCREEN_POS_WIDTH - 1 : 0]  attrb_screen_y,
    input  logic                                 attrb_keep,
    input  logic                                 attrb_last,

    // Fog configuration
    input  logic                                 fog_enable,
    input  pixel_pipeline_pkg::color_t           fog_color,

    // Framebuffer side
    output logic                                 fb_valid,
    output pixel_pipeline_pkg::color_t           fb_color,
    output pixel_pipeline_pkg::depth_t           fb_depth,
    output logic [`PP_INDEX_WIDTH - 1 : 0]       fb_index,
    output logic [`PP_SCREEN_POS_WIDTH - 1 : 0]  fb_screen_x,
    output logic [`PP_SCREEN_POS_WIDTH - 1 : 0]  fb_screen_y,
    output logic                                 fb_keep,
    output logic                                 fb_last
);
    // Valid strobe travels with the sideband
    typedef struct packed {
        logic                          valid;
        pixel_pipeline_pkg::sideband_t sideband;
    } staged_sideband_t;

    staged_sideband_t             sideband_in;
    staged_sideband_t             sideband_out;
    pixel_pipeline_pkg::color_t   conv_color;
    pixel_pipeline_pkg::depth_t   conv_depth;
    pixel_pipeline_pkg::channel_t conv_fog;

    ////////////////////////////////////////
    // Math path
    ////////////////////////////////////////
    attribute_convert u_convert (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .attrb_r       (attrb_r),
        .attrb_g       (attrb_g),
        .attrb_b       (attrb_b),
        .attrb_a       (attrb_a),
        .attrb_depth_z (attrb_depth_z),
        .attrb_depth_w (attrb_depth_w),
        .conv_color    (conv_color),
        .conv_depth    (conv_depth),
        .conv_fog      (conv_fog)
    );

    fog_blend u_fog (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .fog_enable (fog_enable),
        .fog_color  (fog_color),
        .color      (conv_color),
        .fog        (conv_fog),
        .blended    (fb_color)
    );

    // Depth skips the blend stage
    value_delay #(
        .payload_t (pixel_pipeline_pkg::depth_t),
        .DELAY     (`PP_BLEND_LATENCY)
    ) u_depth_delay (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_data  (conv_depth),
        .out_data (fb_depth)
    );

    ////////////////////////////////////////
    // Sideband path
    ////////////////////////////////////////
    assign sideband_in = {attrb_valid, attrb_index, attrb_screen_x, attrb_screen_y,
                          attrb_keep, attrb_last};

    // Matches convert plus blend so the fragment stays aligned
    value_delay #(
        .payload_t (staged_sideband_t),
        .DELAY     (`PP_CONVERT_LATENCY + `PP_BLEND_LATENCY)
    ) u_sideband_delay (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_data  (sideband_in),
        .out_data (sideband_out)
    );

    assign fb_valid    = sideband_out.valid;
    assign fb_index    = sideband_out.sideband.index;
    assign fb_screen_x = sideband_out.sideband.screen_x;
    assign fb_screen_y = sideband_out.sideband.screen_y;
    assign fb_keep     = sideband_out.sideband.keep;
    assign fb_last     = sideband_out.sideband.last;

endmodule

//--- tb/pixel_pipeline_checker.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module pixel_pipeline_checker
(
    input logic                                aclk,
    input logic                                rst_n,
    input logic                                attrb_valid,
    input pixel_pipeline_pkg::float_t          attrb_r,
    input pixel_pipeline_pkg::float_t          attrb_g,
    input pixel_pipeline_pkg::float_t          attrb_b,
    input pixel_pipeline_pkg::float_t          attrb_a,
    input pixel_pipeline_pkg::float_t          attrb_depth_z,
    input pixel_pipeline_pkg::float_t          attrb_depth_w,
    input logic [`PP_INDEX_WIDTH - 1 : 0]      attrb_index,
    input logic [`PP_SCREEN_POS_WIDTH - 1 : 0] attrb_screen_x,
    input logic [`PP_SCREEN_POS_WIDTH - 1 : 0] attrb_screen_y,
    input logic                                attrb_keep,
    input logic                                attrb_last,
    input logic                                fog_enable,
    input pixel_pipeline_pkg::color_t          fog_color,
    input logic                                fb_valid,
    input pixel_pipeline_pkg::color_t          fb_color,
    input pixel_pipeline_pkg::depth_t          fb_depth,
    input logic [`PP_INDEX_WIDTH - 1 : 0]      fb_index,
    input logic [`PP_SCREEN_POS_WIDTH - 1 : 0] fb_screen_x,
    input logic [`PP_SCREEN_POS_WIDTH - 1 : 0] fb_screen_y,
    input logic                                fb_keep,
    input logic                                fb_last
);
    int error_count = 0;

    pixel_pipeline_pkg::color_t   expected_conv;
    pixel_pipeline_pkg::channel_t expected_fog;
    pixel_pipeline_pkg::depth_t   expected_depth;

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////

    // Value times 2^frac truncated and clamped to the fixed range
    function automatic logic [15:0] to_fixed(input pixel_pipeline_pkg::float_t v, input int frac);
        int          scale;
        logic [47:0] product;
        scale = int'(v[30:23]) - 127 + frac;
        if (v[31] || scale < 0)
            return '0;
        if (scale >= frac)
            return 16'((48'd1 << frac) - 1);
        product = {24'd0, 1'b1, v[22:0]} << scale;
        return 16'(product >> 23);
    endfunction

    function automatic pixel_pipeline_pkg::color_t blend_color(
        input pixel_pipeline_pkg::color_t   c,
        input pixel_pipeline_pkg::channel_t f,
        input pixel_pipeline_pkg::color_t   g
    );
        logic [31:0] mixed;
        int          sum;
        for (int i = 0; i < 4; i++)
        begin
            sum = int'(f) * int'(c[8 * i +: 8]) + (255 - int'(f)) * int'(g[8 * i +: 8]) + 128;
            mixed[8 * i +: 8] = 8'(sum >> 8);
        end
        return mixed;
    endfunction

    task automatic record_failure(input string what);
        error_count++;
        $error("%s", what);
    endtask

    assign expected_conv = {8'(to_fixed(attrb_r, `PP_SUB_PIXEL_WIDTH)),
                            8'(to_fixed(attrb_g, `PP_SUB_PIXEL_WIDTH)),
                            8'(to_fixed(attrb_b, `PP_SUB_PIXEL_WIDTH)),
                            8'(to_fixed(attrb_a, `PP_SUB_PIXEL_WIDTH))};
    assign expected_fog   = 8'(to_fixed(attrb_depth_w, `PP_SUB_PIXEL_WIDTH));
    assign expected_depth = to_fixed(attrb_depth_z, `PP_DEPTH_WIDTH);

    ////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////
    assert property (@(posedge aclk) !rst_n |-> !fb_valid)
        else record_failure($sformatf("error: fb_valid 0x%0h during reset, expected 0x0",
            $sampled(fb_valid)));

    assert property (@(posedge aclk) disable iff (!rst_n) fb_valid == $past(attrb_valid, 4))
        else record_failure($sformatf("error: fb_valid 0x%0h, expected 0x%0h",
            $sampled(fb_valid), $past(attrb_valid, 4)));

    assert property (@(posedge aclk) disable iff (!rst_n)
        {fb_index, fb_screen_x, fb_screen_y, fb_keep, fb_last} ==
        $past({attrb_index, attrb_screen_x, attrb_screen_y, attrb_keep, attrb_last}, 4))
        else record_failure($sformatf(
            "error: {fb_index, fb_screen_x, fb_screen_y, fb_keep, fb_last} 0x%0h, expected 0x%0h",
            $sampled({fb_index, fb_screen_x, fb_screen_y, fb_keep, fb_last}),
            $past({attrb_index, attrb_screen_x, attrb_screen_y, attrb_keep, attrb_last}, 4)));

    // Fog state is taken by the blend stage two cycles before the output
    assert property (@(posedge aclk) disable iff (!rst_n)
        fb_valid && !$past(fog_enable, 2) |-> fb_color == $past(expected_conv, 4))
        else record_failure($sformatf("error: fb_color 0x%0h, expected 0x%0h",
            $sampled(fb_color), $past(expected_conv, 4)));

    assert property (@(posedge aclk) disable iff (!rst_n)
        fb_valid && $past(fog_enable, 2) |-> fb_color ==
        blend_color($past(expected_conv, 4), $past(expected_fog, 4), $past(fog_color, 2)))
        else record_failure($sformatf("error: fb_color 0x%0h, expected 0x%0h",
            $sampled(fb_color),
            blend_color($past(expected_conv, 4), $past(expected_fog, 4), $past(fog_color, 2))));

    assert property (@(posedge aclk) disable iff (!rst_n)
        fb_valid |-> fb_depth == $past(expected_depth, 4))
        else record_failure($sformatf("error: fb_depth 0x%0h, expected 0x%0h",
            $sampled(fb_depth), $past(expected_depth, 4)));

endmodule

//--- tb/pixel_pipeline_tb.sv
`timescale 1ns/1ns
`include "pixel_pipeline_params.svh"

module pixel_pipeline_tb;
    localparam int FRAGMENTS = 600;
    localparam int PERIOD    = 8;
    localparam int INDEX_W   = `PP_INDEX_WIDTH;
    localparam int POS_W     = `PP_SCREEN_POS_WIDTH;

    logic                         aclk;
    logic                         rst_n;
    logic                         attrb_valid;
    pixel_pipeline_pkg::float_t   attrb_r;
    pixel_pipeline_pkg::float_t   attrb_g;
    pixel_pipeline_pkg::float_t   attrb_b;
    pixel_pipeline_pkg::float_t   attrb_a;
    pixel_pipeline_pkg::float_t   attrb_depth_z;
    pixel_pipeline_pkg::float_t   attrb_depth_w;
    logic [INDEX_W - 1 : 0]       attrb_index;
    logic [POS_W - 1 : 0]         attrb_screen_x;
    logic [POS_W - 1 : 0]         attrb_screen_y;
    logic                         attrb_keep;
    logic                         attrb_last;
    logic                         fog_enable;
    pixel_pipeline_pkg::color_t   fog_color;
    logic                         fb_valid;
    pixel_pipeline_pkg::color_t   fb_color;
    pixel_pipeline_pkg::depth_t   fb_depth;
    logic [INDEX_W - 1 : 0]       fb_index;
    logic [POS_W - 1 : 0]         fb_screen_x;
    logic [POS_W - 1 : 0]         fb_screen_y;
    logic                         fb_keep;
    logic                         fb_last;

    logic [15:0] lfsr;
    int          sent_count;
    int          received_count;
    int          tb_errors;

    pixel_pipeline u_dut (.*);

    bind pixel_pipeline pixel_pipeline_checker u_checker (.*);

    always #(PERIOD / 2) aclk = ~aclk;

    // 16-bit Galois LFSR stepped once per bit drawn
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
        end
        return bits;
    endfunction

    // Exponent 107..138 reaches below range, in range and saturation for 8 and 16 bits
    function automatic pixel_pipeline_pkg::float_t random_float();
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
        sign     = random_bits(3) == 0;
        exponent = 8'd107 + 8'(random_bits(5));
        mantissa = 23'(random_bits(23));
        return {sign, exponent, mantissa};
    endfunction

    task automatic drive_fragment(input logic fog_on);
        logic valid;
        valid = random_bits(2) != 0;
        @(posedge aclk);
        attrb_valid    <= valid;
        attrb_r        <= random_float();
        attrb_g        <= random_float();
        attrb_b        <= random_float();
        attrb_a        <= random_float();
        attrb_depth_z  <= random_float();
        attrb_depth_w  <= random_float();
        attrb_index    <= INDEX_W'(random_bits(INDEX_W));
        attrb_screen_x <= POS_W'(random_bits(POS_W));
        attrb_screen_y <= POS_W'(random_bits(POS_W));
        attrb_keep     <= random_bits(1) != 0;
        attrb_last     <= random_bits(1) != 0;
        fog_enable     <= fog_on;
        fog_color      <= random_bits(32);
        if (valid)
            sent_count++;
    endtask

    always @(posedge aclk)
    begin
        if (rst_n && fb_valid)
            received_count <= received_count + 1;
    end

    initial
    begin
        #((FRAGMENTS + 20) * PERIOD);
        $display("Watchdog expired before the pipeline drained");
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        aclk           = 1'b0;
        rst_n          = 1'b1;
        attrb_valid    = 1'b0;
        attrb_r        = '0;
        attrb_g        = '0;
        attrb_b        = '0;
        attrb_a        = '0;
        attrb_depth_z  = '0;
        attrb_depth_w  = '0;
        attrb_index    = '0;
        attrb_screen_x = '0;
        attrb_screen_y = '0;
        attrb_keep     = 1'b0;
        attrb_last     = 1'b0;
        fog_enable     = 1'b0;
        fog_color      = '0;
        lfsr           = 16'd6953;
        sent_count     = 0;
        received_count = 0;
        tb_errors      = 0;
        #1 rst_n = 1'b0;
        repeat (4) @(posedge aclk);
        rst_n <= 1'b1;

        // First half without fog and second half with fog
        for (int i = 0; i < FRAGMENTS; i++)
            drive_fragment(i >= FRAGMENTS / 2);
        @(posedge aclk);
        attrb_valid <= 1'b0;

        wait (received_count == sent_count);
        repeat (`PP_CONVERT_LATENCY + `PP_BLEND_LATENCY) @(posedge aclk);
        if (received_count != sent_count)
        begin
            tb_errors++;
            $display("error: fb_valid count 0x%0h, expected 0x%0h", received_count, sent_count);
        end

        $display("Errors: %0d testbench, %0d assertion, over %0d fragments",
                 tb_errors, u_dut.u_checker.error_count, sent_count);
        if (tb_errors + u_dut.u_checker.error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/pixel_pipeline_pkg.sv
rtl/float_to_fixed.sv
rtl/attribute_convert.sv
rtl/value_delay.sv
rtl/fog_blend.sv
rtl/pixel_pipeline.sv
tb/pixel_pipeline_checker.sv
tb/pixel_pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pixel pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
    --top-module pixel_pipeline_tb -o pixel_pipeline_sim || exit 1
output=$(./obj_dir/pixel_pipeline_sim +verilator+error+limit+1000)
echo "$output"
echo "$output" | grep -q "^Result: PASSED$" && exit 0 || exit 1
